// File: compile.f
rtl/routerPkg.sv
rtl/portTimer.sv
rtl/grantArbiter.sv
rtl/flitStage.sv
rtl/outputMux.sv
rtl/routerOutputPort.sv
verif/routerOutputPort_assert.sv
verif/routerTb.sv

// File: Makefile
# Verilator build for the router output port testbench

VERILATOR ?= verilator
TOP       ?= routerTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
run: compile
	./$(SIM_BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/routerTb.sv
`timescale 1ns/1ns

module routerTb import routerPkg::*; ();

  localparam logic [11:0] HoldCap = 12'd6;   // Small so long packets reach the cap
  localparam int          Timeout = 100;

  logic     clk = 1'b0;
  logic     rst;
  portIn_t  portsIn [NumPorts];
  flit_u    outFlit;
  logic     outValid;
  portIdx_t outPort;
  logic     pktDone;
  grant_t   grant;

  logic [31:0] lfsrState = 32'hf638;
  string       testName;
  int          errorCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          flitChecks = 0;
  int          mark;

  routerOutputPort #(
    .MaxHold(HoldCap)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .portsIn  (portsIn),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort),
    .pktDone  (pktDone),
    .grant    (grant)
  );

  bind routerOutputPort routerOutputPort_assert #(.MaxHold(MaxHold)) asserts0 (.*);

  always #50 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hB4BCD35C) : (lfsrState >> 1);
    end
    return v;
  endfunction

  function automatic flit_u makeHead(input logic [11:0] len);
    flit_u       f;
    logic [31:0] r;
    r = randBits(17);
    f.head.kind      = KindHead;
    f.head.pktLength = len;
    f.head.srcTag    = r[16:0];
    return f;
  endfunction

  function automatic flit_u makeData(input flitKind_t kind);
    flit_u       f;
    logic [31:0] r;
    r = randBits(29);
    f.body.kind    = kind;
    f.body.payload = r[28:0];
    return f;
  endfunction

  function automatic int problems();
    return errorCount + dut0.asserts0.failCount;
  endfunction

  task automatic clearPorts();
    for (int p = 0; p < NumPorts; p++)
      portsIn[p] = '0;
  endtask

  task automatic drive(input portIdx_t p, input logic req, input flit_u f);
    portsIn[p].req  = req;
    portsIn[p].flit = f;
  endtask

  // Compare the output at the falling edge with the flit driven a cycle ago
  task automatic tick();
    @(negedge clk);
    if (outValid)
    begin
      flitChecks++;
      if (!portsIn[outPort].req)
      begin
        $display("%s: output valid on port %0d with no request driven", testName, outPort);
        errorCount++;
      end
      else if (outFlit !== portsIn[outPort].flit)
      begin
        $display("** Error: %s port %0d expected %h actual %h", testName, outPort,
                 portsIn[outPort].flit, outFlit);
        errorCount++;
      end
    end
  endtask

  // The flit driven on port p a cycle ago must be on the output now
  task automatic expectOutput(input portIdx_t p);
    if (!outValid)
    begin
      $display("%s: no output flit one cycle after driving port %0d", testName, p);
      errorCount++;
    end
    else if (outPort != p)
    begin
      $display("** Error: %s outPort expected %0d actual %0d", testName, p, outPort);
      errorCount++;
    end
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    while (grant != GrantIdle && n < Timeout)
    begin
      tick();
      n++;
    end
    if (grant != GrantIdle)
    begin
      $display("%s: timed out waiting for the grant to go idle", testName);
      errorCount++;
    end
  endtask

  task automatic beginTest(input string name);
    testName = name;
    mark     = problems();
  endtask

  task automatic endTest();
    testsRun++;
    if (problems() == mark)
      $display("%s: ok", testName);
    else
    begin
      testsFailed++;
      $display("%s: %0d problems", testName, problems() - mark);
    end
  endtask

  task automatic resetQuiet();
    beginTest("resetQuiet");
    for (int i = 0; i < 4; i++)
    begin
      tick();
      if (grant != GrantIdle || outValid || pktDone)
      begin
        $display("%s: output active with no request", testName);
        errorCount++;
      end
    end
    endTest();
  endtask

  task automatic singlePort(input portIdx_t p, input int bodies);
    logic [31:0] r;
    logic        seen;
    beginTest("singlePort");
    r = randBits(4);
    tick();
    drive(p, 1'b1, makeHead(r[11:0] + 12'd1));
    for (int i = 0; i < bodies; i++)
    begin
      tick();
      expectOutput(p);
      drive(p, 1'b1, makeData(KindBody));
    end
    tick();
    expectOutput(p);
    drive(p, 1'b1, makeData(KindTail));
    seen = 1'b0;
    for (int i = 0; i < Timeout && !seen; i++)
    begin
      tick();
      if (i == 0)
        expectOutput(p);
      seen = pktDone;
      clearPorts();
    end
    if (!seen)
    begin
      $display("%s: timed out waiting for pktDone", testName);
      errorCount++;
    end
    endTest();
  endtask

  // North sends a packet while West keeps requesting
  task automatic holdBound(input string name, input logic [11:0] len, input int further);
    beginTest(name);
    tick();
    drive(PortNorth, 1'b1, makeHead(len));
    drive(PortWest, 1'b1, '0);
    for (int i = 0; i < further; i++)
    begin
      tick();
      drive(PortNorth, 1'b1, makeData((i == further - 1) ? KindTail : KindBody));
    end
    tick();
    clearPorts();
    waitIdle();
    endTest();
  endtask

  task automatic rotation(input int cycles);
    logic [31:0] r;
    beginTest("rotation");
    for (int i = 0; i < cycles; i++)
    begin
      tick();
      r = randBits(NumPorts);
      for (int p = 0; p < NumPorts; p++)
        drive(portIdx_t'(p), r[p], '0);
    end
    tick();
    clearPorts();
    waitIdle();
    endTest();
  endtask

  task automatic idleFallback();
    beginTest("idleFallback");
    tick();
    for (int p = 0; p < NumPorts; p++)
      drive(portIdx_t'(p), 1'b1, '0);
    for (int i = 0; i < 3; i++)
      tick();
    clearPorts();
    waitIdle();
    if (outValid)
    begin
      $display("%s: outValid high with the grant idle", testName);
      errorCount++;
    end
    endTest();
  endtask

  // Body and tail on South with no head before them
  task automatic orphan();
    beginTest("orphan");
    for (int i = 0; i < 4; i++)
    begin
      tick();
      if ((outValid && outPort == PortSouth) || pktDone)
      begin
        $display("%s: orphan flit on port %0d leaked to the output", testName, PortSouth);
        errorCount++;
      end
      if (i == 0)
        drive(PortSouth, 1'b1, makeData(KindBody));
      else if (i == 1)
        drive(PortSouth, 1'b1, makeData(KindTail));
      else
        clearPorts();
    end
    waitIdle();
    endTest();
  endtask

  initial
  begin
    clearPorts();
    rst = 1'b1;
    for (int i = 0; i < 3; i++)
      @(negedge clk);
    rst = 1'b0;
    resetQuiet();
    singlePort(PortEast, 3);
    holdBound("holdBound", 12'd2, 3);
    holdBound("holdCap", 12'd20, 10);
    rotation(80);
    idleFallback();
    orphan();
    $display("%0d tests, %0d failed, %0d flits checked, %0d errors, %0d assertion failures",
             testsRun, testsFailed, flitChecks, errorCount, dut0.asserts0.failCount);
    if (testsFailed == 0 && problems() == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verif/routerOutputPort_assert.sv
`timescale 1ns/1ns

module routerOutputPort_assert import routerPkg::*; #(
  parameter logic [11:0] MaxHold = 12'd64
) (
  input logic     clk,
  input logic     rst,
  input portIn_t  portsIn [NumPorts],
  input flit_u    outFlit,
  input logic     outValid,
  input portIdx_t outPort,
  input logic     pktDone,
  input grant_t   grant
);

  int                  failCount = 0;
  portIn_t             prevIn [NumPorts];
  logic [NumPorts-1:0] reqsNow;
  logic [NumPorts-1:0] prevReqs;
  logic [NumPorts-1:0] isOpen;
  logic [NumPorts-1:0] prevOrphan;
  logic [11:0]         holdLimit [NumPorts];
  grant_t              prevGrant;
  grant_t              expectGrant;
  logic                othersNow;
  logic                prevOthers;
  int                  gIdx;
  int                  prevGIdx;
  int                  runLen;
  int                  runNow;

  task automatic reportFail(input string what);
    failCount++;
    $error("%s", what);
  endtask

  // First requester after port 'after' with that port itself last
  function automatic grant_t nextInRing(input int after, input logic [NumPorts-1:0] r);
    grant_t g;
    int     p;
    g = GrantIdle;
    for (int k = NumPorts; k >= 1; k--)
    begin
      p = (after + k) % NumPorts;
      if (r[p])
        g = grant_t'(1) << (p + 1);
    end
    return g;
  endfunction

  always_comb
  begin
    gIdx = 0;
    for (int p = 0; p < NumPorts; p++)
    begin
      reqsNow[p] = portsIn[p].req;
      if (grant[p + 1])
        gIdx = p;
    end
    othersNow   = |(reqsNow & ~grant[NumPorts:1]);
    runNow      = (grant == prevGrant && prevOthers) ? runLen + 1 : 1;   // Counts only contested holds
    expectGrant = nextInRing((prevGrant == GrantIdle) ? NumPorts - 1 : prevGIdx, prevReqs);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prevGrant  <= GrantIdle;
      prevGIdx   <= 0;
      prevReqs   <= '0;
      prevOthers <= 1'b0;
      runLen     <= 0;
      isOpen     <= '0;
      prevOrphan <= '0;
      for (int p = 0; p < NumPorts; p++)
      begin
        prevIn[p]    <= '0;
        holdLimit[p] <= '0;
      end
    end
    else
    begin
      prevGrant  <= grant;
      prevGIdx   <= gIdx;
      prevReqs   <= reqsNow;
      prevOthers <= othersNow;
      runLen     <= runNow;
      for (int p = 0; p < NumPorts; p++)
      begin
        prevIn[p]     <= portsIn[p];
        prevOrphan[p] <= portsIn[p].req && !isOpen[p] &&
                         (portsIn[p].flit.body.kind inside {KindBody, KindTail});
        if (portsIn[p].flit.head.kind == KindHead)
          holdLimit[p] <= (portsIn[p].flit.head.pktLength < MaxHold) ?
                          portsIn[p].flit.head.pktLength : MaxHold;
        if (portsIn[p].req && portsIn[p].flit.head.kind == KindHead)
          isOpen[p] <= 1'b1;
        else if (portsIn[p].req && portsIn[p].flit.body.kind == KindTail)
          isOpen[p] <= 1'b0;
      end
    end
  end

  aOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else reportFail("grant is not one-hot");

  aIdleQuiet: assert property (@(posedge clk) disable iff (rst)
    grant == GrantIdle |-> !outValid && !pktDone)
    else reportFail("output active while the grant is idle");

  // Output is the granted port's flit from one cycle earlier
  aForward: assert property (@(posedge clk) disable iff (rst)
    outValid |-> prevIn[outPort].req && outFlit == prevIn[outPort].flit && outPort == gIdx)
    else reportFail("output flit does not match the flit driven one cycle earlier");

  aDoneTail: assert property (@(posedge clk) disable iff (rst)
    pktDone == (outValid && outFlit.body.kind == KindTail))
    else reportFail("pktDone does not match a forwarded tail");

  aHoldLimit: assert property (@(posedge clk) disable iff (rst)
    grant != GrantIdle |-> runNow <= holdLimit[gIdx] + 1)
    else reportFail("port held the grant past its capped length");

  aRotate: assert property (@(posedge clk) disable iff (rst)
    (grant != prevGrant || prevGrant == GrantIdle) && prevReqs != '0 |-> grant == expectGrant)
    else reportFail("new grant is not the next requester in rotating order");

  aIdleFallback: assert property (@(posedge clk) disable iff (rst)
    prevReqs == '0 |-> grant == GrantIdle && !outValid)
    else reportFail("grant not idle one cycle after all requests dropped");

  aOrphan: assert property (@(posedge clk) disable iff (rst)
    outValid |-> !prevOrphan[outPort])
    else reportFail("orphan body or tail flit reached the output");

endmodule

// File: rtl/routerOutputPort.sv
`timescale 1ns/1ns

module routerOutputPort import routerPkg::*; #(
  parameter logic [11:0] MaxHold = 12'd64
) (
  input  logic     clk,
  input  logic     rst,
  input  portIn_t  portsIn [NumPorts],
  output flit_u    outFlit,
  output logic     outValid,
  output portIdx_t outPort,
  output logic     pktDone,
  output grant_t   grant
);

  portIn_t             staged [NumPorts];
  logic [NumPorts-1:0] stagedOpen;

  grantArbiter #(
    .MaxHold(MaxHold)
  ) arbiter0 (
    .clk     (clk),
    .rst     (rst),
    .portsIn (portsIn),
    .grant   (grant)
  );

  // Flits line up with the registered grant
  flitStage stage0 (
    .clk        (clk),
    .rst        (rst),
    .portsIn    (portsIn),
    .staged     (staged),
    .stagedOpen (stagedOpen)
  );

  outputMux mux0 (
    .grant      (grant),
    .staged     (staged),
    .stagedOpen (stagedOpen),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .outPort    (outPort),
    .pktDone    (pktDone)
  );

endmodule

// File: rtl/outputMux.sv
`timescale 1ns/1ns

module outputMux import routerPkg::*; (
  input  grant_t              grant,
  input  portIn_t             staged [NumPorts],
  input  logic [NumPorts-1:0] stagedOpen,
  output flit_u               outFlit,
  output logic                outValid,
  output portIdx_t            outPort,
  output logic                pktDone
);

  portIdx_t sel;
  logic     granted;
  portIn_t  picked;

  // One-hot grant to port index
  always_comb
  begin
    granted = 1'b1;
    case (grant)
      GrantLocal: sel = PortLocal;
      GrantNorth: sel = PortNorth;
      GrantEast:  sel = PortEast;
      GrantWest:  sel = PortWest;
      GrantSouth: sel = PortSouth;
      default:
      begin
        sel     = PortLocal;   // Idle
        granted = 1'b0;
      end
    endcase
  end

  assign picked   = staged[sel];
  assign outValid = granted && picked.req;
  assign outFlit  = outValid ? picked.flit : '0;
  assign outPort  = sel;

  // A forwarded tail has already closed its port's packet
  assign pktDone = outValid && (picked.flit.body.kind == KindTail) && !stagedOpen[sel];

endmodule

// File: rtl/flitStage.sv
`timescale 1ns/1ns

module flitStage import routerPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  portIn_t             portsIn [NumPorts],
  output portIn_t             staged [NumPorts],
  output logic [NumPorts-1:0] stagedOpen
);

  logic [NumPorts-1:0] isHead;
  logic [NumPorts-1:0] isTail;
  logic [NumPorts-1:0] orphan;
  logic [NumPorts-1:0] openNext;
  logic [NumPorts-1:0] stagedReq;
  flit_u               stagedFlit [NumPorts];

  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    assign isHead[p] = portsIn[p].req && (portsIn[p].flit.head.kind == KindHead);
    assign isTail[p] = portsIn[p].req && (portsIn[p].flit.body.kind == KindTail);

    // Body or tail with no packet open on this port
    assign orphan[p] = portsIn[p].req && !stagedOpen[p] &&
                       ((portsIn[p].flit.body.kind == KindBody) ||
                        (portsIn[p].flit.body.kind == KindTail));

    assign openNext[p] = isHead[p] || (stagedOpen[p] && !isTail[p]);

    assign staged[p] = {stagedReq[p], stagedFlit[p]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stagedReq  <= '0;
      stagedOpen <= '0;
    end
    else
    begin
      stagedReq  <= reqsIn() & ~orphan;
      stagedOpen <= openNext;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NumPorts; p++)
      stagedFlit[p] <= portsIn[p].flit;
  end

  function automatic logic [NumPorts-1:0] reqsIn();
    logic [NumPorts-1:0] r;
    for (int p = 0; p < NumPorts; p++)
      r[p] = portsIn[p].req;
    return r;
  endfunction

endmodule

// File: rtl/grantArbiter.sv
`timescale 1ns/1ns

module grantArbiter import routerPkg::*; #(
  parameter logic [11:0] MaxHold = 12'd64
) (
  input  logic    clk,
  input  logic    rst,
  input  portIn_t portsIn [NumPorts],
  output grant_t  grant
);

  logic [NumPorts-1:0] reqs;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;
  grant_t              nextGrant;

  // First requester at or after start with wraparound, or idle when nobody asks
  function automatic grant_t firstReq(input int start, input logic [NumPorts-1:0] r);
    grant_t g;
    int     idx;
    g = GrantIdle;
    for (int off = NumPorts - 1; off >= 0; off--)
    begin
      idx = start + off;
      if (idx >= NumPorts)
        idx = idx - NumPorts;
      if (r[idx])
      begin
        g          = '0;
        g[idx + 1] = 1'b1;   // Lowest offset is visited last and wins
      end
    end
    return g;
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    assign reqs[p] = portsIn[p].req;

    portTimer #(
      .MaxHold(MaxHold)
    ) timer0 (
      .clk     (clk),
      .rst     (rst),
      .flit    (portsIn[p].flit),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  always_comb
  begin
    nextGrant = GrantIdle;
    runTimer  = '0;
    if (grant == GrantIdle)
      nextGrant = firstReq(0, reqs);
    else if ($onehot(grant))
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (grant[p + 1])
        begin
          if (reqs[p] && !timesUp[p])
          begin
            nextGrant   = grant;   // Hold
            runTimer[p] = 1'b1;
          end
          else
          begin
            // Rotate so the current port comes last
            nextGrant = firstReq(p + 1, reqs);
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= GrantIdle;
    else
      grant <= nextGrant;
  end

endmodule

// File: rtl/portTimer.sv
`timescale 1ns/1ns

module portTimer import routerPkg::*; #(
  parameter logic [11:0] MaxHold = 12'd64
) (
  input  logic  clk,
  input  logic  rst,
  input  flit_u flit,
  input  logic  run,
  output logic  timesUp
);

  logic [11:0] limit;
  logic [11:0] count;
  logic [11:0] capped;

  assign capped = (flit.head.pktLength < MaxHold) ? flit.head.pktLength : MaxHold;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flit.head.kind == KindHead)
        limit <= capped;   // Reloaded on every head
      if (run)
        count <= count + 12'd1;
      else
        count <= '0;
    end
  end

  // Expiry ends the hold after limit plus one granted cycles
  assign timesUp = (count == limit);

endmodule

// File: rtl/routerPkg.sv
package routerPkg;

  localparam int NumPorts = 5;

  // Fixed port order Local, North, East, West, South
  typedef logic [2:0] portIdx_t;

  localparam portIdx_t PortLocal = 3'd0;
  localparam portIdx_t PortNorth = 3'd1;
  localparam portIdx_t PortEast  = 3'd2;
  localparam portIdx_t PortWest  = 3'd3;
  localparam portIdx_t PortSouth = 3'd4;

  typedef enum logic [2:0] {
    KindIdle = 3'd0,
    KindHead = 3'd1,
    KindBody = 3'd2,
    KindTail = 3'd4
  } flitKind_t;

  typedef struct packed {
    flitKind_t   kind;
    logic [11:0] pktLength;
    logic [16:0] srcTag;
  } headFlit_t;

  typedef struct packed {
    flitKind_t   kind;
    logic [28:0] payload;
  } bodyFlit_t;

  // One word read as head or as data depending on kind
  typedef union packed {
    headFlit_t head;
    bodyFlit_t body;
  } flit_u;

  typedef struct packed {
    logic  req;
    flit_u flit;
  } portIn_t;

  // One-hot with bit 0 as idle
  typedef logic [5:0] grant_t;

  localparam grant_t GrantIdle  = 6'b000001;
  localparam grant_t GrantLocal = 6'b000010;
  localparam grant_t GrantNorth = 6'b000100;
  localparam grant_t GrantEast  = 6'b001000;
  localparam grant_t GrantWest  = 6'b010000;
  localparam grant_t GrantSouth = 6'b100000;

endpackage
